// ==== Bender.yml ====
package:
  name: rvfi_trace

sources:
  - rv_isa_pkg.sv
  - trace_pkg.sv
  - compressed_decoder.sv
  - trace_encoder.sv
  - trace_arbiter.sv
  - trace_fifo.sv
  - rvfi_trace_top.sv
  - target: test
    files:
      - rvfi_trace_sva.sv
      - tb_rvfi_trace.sv

// ==== compressed_decoder.sv ====
/*
  Combinational RV32C to RV32I expansion, integer subset only.
  Compressed floating-point loads and stores are reported as illegal.
  Only instr_i[15:0] is looked at for a compressed word. An illegal word is
  passed through unchanged.
*/
`timescale 1ns/1ps

module compressed_decoder
  import rv_isa_pkg::*;
(
  input  logic [31:0] instr_i,
  output logic [31:0] instr_o,
  output logic        is_compressed_o,
  output logic        illegal_o
);

  logic [31:0] exp;
  logic        illegal;

  always_comb begin
    illegal = 1'b0;
    exp = instr_i;
    case (instr_i[1:0])
      C_Q0: begin
        case (instr_i[15:13])
          3'b000: begin
            // c.addi4spn, zero immediate covers the all-zero halfword
            exp = {2'b00, instr_i[10:7], instr_i[12:11], instr_i[5], instr_i[6], 2'b00,
                   REG_SP, F3_ADD, 2'b01, instr_i[4:2], OPC_OP_IMM};
            if (instr_i[12:5] == 8'h00) illegal = 1'b1;
          end
          3'b010: begin
            exp = {5'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00,
                   2'b01, instr_i[9:7], F3_W, 2'b01, instr_i[4:2], OPC_LOAD};
          end
          3'b110: begin
            exp = {5'b0, instr_i[5], instr_i[12], 2'b01, instr_i[4:2], 2'b01, instr_i[9:7],
                   F3_W, instr_i[11:10], instr_i[6], 2'b00, OPC_STORE};
          end
          default: illegal = 1'b1;
        endcase
      end

      C_Q1: begin
        case (instr_i[15:13])
          3'b000: begin
            exp = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], instr_i[11:7], F3_ADD,
                   instr_i[11:7], OPC_OP_IMM};
          end
          3'b001, 3'b101: begin
            // c.jal links to ra, c.j to x0
            exp = {instr_i[12], instr_i[8], instr_i[10:9], instr_i[6], instr_i[7], instr_i[2],
                   instr_i[11], instr_i[5:3], {9{instr_i[12]}}, 4'b0, ~instr_i[15], OPC_JAL};
          end
          3'b010: begin
            exp = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], REG_ZERO, F3_ADD,
                   instr_i[11:7], OPC_OP_IMM};
          end
          3'b011: begin
            if (instr_i[11:7] == REG_SP) begin
              // c.addi16sp
              exp = {{3{instr_i[12]}}, instr_i[4:3], instr_i[5], instr_i[2], instr_i[6], 4'b0,
                     REG_SP, F3_ADD, REG_SP, OPC_OP_IMM};
            end else begin
              exp = {{15{instr_i[12]}}, instr_i[6:2], instr_i[11:7], OPC_LUI};
            end
            if ({instr_i[12], instr_i[6:2]} == 6'b0) illegal = 1'b1;
          end
          3'b100: begin
            case (instr_i[11:10])
              2'b00, 2'b01: begin
                // c.srli and c.srai, shamt[5] is reserved on RV32
                exp = {1'b0, instr_i[10], 5'b0, instr_i[6:2], 2'b01, instr_i[9:7], F3_SR,
                       2'b01, instr_i[9:7], OPC_OP_IMM};
                if (instr_i[12]) illegal = 1'b1;
              end
              2'b10: begin
                exp = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], 2'b01, instr_i[9:7],
                       F3_AND, 2'b01, instr_i[9:7], OPC_OP_IMM};
              end
              default: begin
                exp = {1'b0, (instr_i[6:5] == 2'b00), 5'b0, 2'b01, instr_i[4:2],
                       2'b01, instr_i[9:7], F3_ADD, 2'b01, instr_i[9:7], OPC_OP};
                case (instr_i[6:5])
                  2'b01: exp[14:12] = F3_XOR;
                  2'b10: exp[14:12] = F3_OR;
                  2'b11: exp[14:12] = F3_AND;
                  default: exp[14:12] = F3_ADD;
                endcase
                // RV64 subw/addw space
                if (instr_i[12]) illegal = 1'b1;
              end
            endcase
          end
          default: begin
            // c.beqz / c.bnez
            exp = {{4{instr_i[12]}}, instr_i[6:5], instr_i[2], REG_ZERO, 2'b01, instr_i[9:7],
                   2'b00, instr_i[13], instr_i[11:10], instr_i[4:3], instr_i[12], OPC_BRANCH};
          end
        endcase
      end

      C_Q2: begin
        case (instr_i[15:13])
          3'b000: begin
            exp = {7'b0, instr_i[6:2], instr_i[11:7], F3_SLL, instr_i[11:7], OPC_OP_IMM};
            if (instr_i[12]) illegal = 1'b1;
          end
          3'b010: begin
            exp = {4'b0, instr_i[3:2], instr_i[12], instr_i[6:4], 2'b00, REG_SP, F3_W,
                   instr_i[11:7], OPC_LOAD};
            if (instr_i[11:7] == REG_ZERO) illegal = 1'b1;
          end
          3'b100: begin
            if (instr_i[6:2] != REG_ZERO) begin
              // c.mv adds to x0, c.add to rd
              exp = {7'b0, instr_i[6:2], instr_i[12] ? instr_i[11:7] : REG_ZERO, F3_ADD,
                     instr_i[11:7], OPC_OP};
            end else if (instr_i[12] && instr_i[11:7] == REG_ZERO) begin
              exp = {12'h001, 13'b0, OPC_SYSTEM};
            end else begin
              exp = {12'b0, instr_i[11:7], F3_ADD, instr_i[12] ? REG_RA : REG_ZERO, OPC_JALR};
              if (instr_i[11:7] == REG_ZERO) illegal = 1'b1;
            end
          end
          3'b110: begin
            exp = {4'b0, instr_i[8:7], instr_i[12], instr_i[6:2], REG_SP, F3_W,
                   instr_i[11:9], 2'b00, OPC_STORE};
          end
          default: illegal = 1'b1;
        endcase
      end

      default: exp = instr_i;
    endcase
  end

  assign is_compressed_o = (instr_i[1:0] != 2'b11);
  assign illegal_o       = illegal;
  assign instr_o         = illegal ? instr_i : exp;

endmodule

// ==== rv_isa_pkg.sv ====
/*
  RISC-V encoding definitions shared by the decoder and the trace encoder.
  Covers RV32I major opcodes and the integer RV32C quadrants only.
  Floating point and custom opcodes are not listed and fall into OPC_OTHER.
*/
package rv_isa_pkg;

  // Major opcodes, bits [6:0] of a 32-bit instruction
  typedef enum logic [6:0] {
    OPC_OTHER  = 7'b0000000,
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // Immediate layout of an instruction, as carried in a trace record
  typedef enum logic [2:0] {
    FMT_NONE,
    FMT_I,
    FMT_S,
    FMT_B,
    FMT_U,
    FMT_J
  } imm_fmt_e;

  // Compressed quadrants, bits [1:0] of a 16-bit word
  localparam logic [1:0] C_Q0 = 2'b00;
  localparam logic [1:0] C_Q1 = 2'b01;
  localparam logic [1:0] C_Q2 = 2'b10;

  // funct3 values the RV32C expansion produces
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_W   = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_SR  = 3'b101;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  localparam logic [4:0] REG_ZERO = 5'd0;
  localparam logic [4:0] REG_RA   = 5'd1;
  localparam logic [4:0] REG_SP   = 5'd2;

endpackage

// ==== rvfi_trace_sva.sv ====
/*
  Four-phase link checks, bound to the encoder hand-off and the FIFO drain
  port. Checks are inactive while rst_ni is low.
*/
`timescale 1ns/1ps

module rvfi_trace_sva
  import trace_pkg::*;
(
  input logic       clk_i,
  input logic       rst_ni,
  input logic       req_i,
  input logic       ack_i,
  input trace_rec_t rec_i
);

  // Req stays up until it is acknowledged
  req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && !ack_i |=> req_i)
    else $error("four-phase req dropped before ack");

  ack_needs_req_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(ack_i) |-> req_i)
    else $error("four-phase ack rose without req");

  rec_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |=> !req_i || $stable(rec_i))
    else $error("record changed while req was high");

  // A new request waits for the previous ack to fall
  req_after_ack_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(req_i) |-> !ack_i)
    else $error("four-phase req rose while ack was high");

endmodule

bind trace_encoder rvfi_trace_sva u_rec_sva (
  .clk_i (clk_i),
  .rst_ni(rst_ni),
  .req_i (rec_req_o),
  .ack_i (rec_ack_i),
  .rec_i (rec_o)
);

bind trace_fifo rvfi_trace_sva u_out_sva (
  .clk_i (clk_i),
  .rst_ni(rst_ni),
  .req_i (out_req_o),
  .ack_i (out_ack_i),
  .rec_i (out_rec_o)
);

// ==== rvfi_trace_top.sv ====
/*
  Retirement trace unit: one encoder per hart, a round-robin arbiter and a
  shared record FIFO drained by the host over four-phase req/ack.
  NUM_HARTS is limited to 2**HART_W. FIFO_DEPTH must be a power of two.
*/
`timescale 1ns/1ps

module rvfi_trace_top
  import trace_pkg::*;
#(
  parameter int NUM_HARTS  = 2,
  parameter int FIFO_DEPTH = 8
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       retire_valid_i [NUM_HARTS],
  input  retire_t    retire_i       [NUM_HARTS],
  output logic       retire_ready_o [NUM_HARTS],
  output logic       out_req_o,
  output trace_rec_t out_rec_o,
  input  logic       out_ack_i
);

  logic       rec_req [NUM_HARTS];
  trace_rec_t rec     [NUM_HARTS];
  logic       rec_ack [NUM_HARTS];
  logic       push, full;
  trace_rec_t push_rec;

  for (genvar h = 0; h < NUM_HARTS; h++) begin : g_hart
    trace_encoder #(
      .HART_ID(h)
    ) u_enc (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .retire_valid_i(retire_valid_i[h]),
      .retire_i      (retire_i[h]),
      .retire_ready_o(retire_ready_o[h]),
      .rec_req_o     (rec_req[h]),
      .rec_o         (rec[h]),
      .rec_ack_i     (rec_ack[h])
    );
  end

  trace_arbiter #(
    .NUM_HARTS(NUM_HARTS)
  ) u_arb (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (rec_req),
    .rec_i     (rec),
    .ack_o     (rec_ack),
    .push_o    (push),
    .push_rec_o(push_rec),
    .full_i    (full)
  );

  trace_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .push_i    (push),
    .push_rec_i(push_rec),
    .full_o    (full),
    .out_req_o (out_req_o),
    .out_rec_o (out_rec_o),
    .out_ack_i (out_ack_i)
  );

endmodule

// ==== tb_rvfi_trace.sv ====
/*
  Directed testbench for the retirement trace unit with two harts and an
  8-deep FIFO. Expected records come from a table of known encodings and
  the immediate rules per format. Only table instructions are retired.
  The pc of a retirement carries the hart number in bits [31:28].
  The host side of the FIFO port is driven here with four-phase req/ack.
*/
`timescale 1ns/1ps

module tb_rvfi_trace
  import rv_isa_pkg::*, trace_pkg::*;
();

  localparam int NUM_HARTS      = 2;
  localparam int FIFO_DEPTH     = 8;
  localparam int NUM_INSN       = 17;
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int STALL_CYCLES   = 16;

  typedef struct packed {
    logic [31:0] raw;
    logic [31:0] exp;
    logic        cmp;
    logic        ill;
  } insn_entry_t;

  // Raw retired word, expected expanded word, compressed flag, illegal flag
  insn_entry_t insn_tbl [NUM_INSN] = '{
    '{32'hFFD30293, 32'hFFD30293, 1'b0, 1'b0},  // addi x5, x6, -3
    '{32'h00812383, 32'h00812383, 1'b0, 1'b0},  // lw x7, 8(x2)
    '{32'hF14020F3, 32'hF14020F3, 1'b0, 1'b0},  // csrrs x1, mhartid, x0
    '{32'hFE84AE23, 32'hFE84AE23, 1'b0, 1'b0},  // sw x8, -4(x9)
    '{32'hFE019CE3, 32'hFE019CE3, 1'b0, 1'b0},  // bne x3, x0, -8
    '{32'h12345537, 32'h12345537, 1'b0, 1'b0},  // lui x10, 0x12345
    '{32'h001000EF, 32'h001000EF, 1'b0, 1'b0},  // jal x1, 2048
    '{32'h005201B3, 32'h005201B3, 1'b0, 1'b0},  // add x3, x4, x5
    '{32'h0000147D, 32'hFFF40413, 1'b1, 1'b0},  // c.addi x8, -1
    '{32'h00004515, 32'h00500513, 1'b1, 1'b0},  // c.li x10, 5
    '{32'h00004144, 32'h00452483, 1'b1, 1'b0},  // c.lw x9, 4(x10)
    '{32'h0000C504, 32'h00952423, 1'b1, 1'b0},  // c.sw x9, 8(x10)
    '{32'h0000BFFD, 32'hFFFFF06F, 1'b1, 1'b0},  // c.j -2
    '{32'h0000C401, 32'h00040463, 1'b1, 1'b0},  // c.beqz x8, 8
    '{32'h000085B2, 32'h00C005B3, 1'b1, 1'b0},  // c.mv x11, x12
    '{32'h000095B2, 32'h00C585B3, 1'b1, 1'b0},  // c.add x11, x12
    '{32'h00000000, 32'h00000000, 1'b1, 1'b1}   // all-zero halfword
  };

  logic        clk;
  logic        rst_n;
  logic        retire_valid [NUM_HARTS];
  retire_t     retire       [NUM_HARTS];
  logic        retire_ready [NUM_HARTS];
  logic        out_req;
  trace_rec_t  out_rec;
  logic        out_ack;
  logic [15:0] edge_cnt  = '0;
  int          cycle_cnt = 0;
  integer      seed;
  trace_rec_t  exp_q [NUM_HARTS][$];

  rvfi_trace_top #(
    .NUM_HARTS (NUM_HARTS),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) uut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .retire_valid_i(retire_valid),
    .retire_i      (retire),
    .retire_ready_o(retire_ready),
    .out_req_o     (out_req),
    .out_rec_o     (out_rec),
    .out_ack_i     (out_ack)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Edges since reset release, the first one counts as 0
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) edge_cnt <= '0;
    else edge_cnt <= edge_cnt + 1'b1;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Run hung: no end of test after %0d cycles", cycle_cnt);
      $display("Regression failed");
      $fatal(1, "timeout");
    end
  end

  task automatic expect_equal(input string what, input logic [31:0] got,
                              input logic [31:0] want);
    assert (got === want) else begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, want);
      $display("Regression failed");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  task automatic require(input logic ok, input string what);
    assert (ok) else begin
      $display("%0t: %s", $time, what);
      $display("Regression failed");
      $fatal(1, "%s", what);
    end
  endtask

  function automatic imm_fmt_e fmt_of(input logic [31:0] insn);
    case (insn[6:0])
      OPC_LOAD, OPC_JALR, OPC_OP_IMM, OPC_SYSTEM: return FMT_I;
      OPC_STORE:          return FMT_S;
      OPC_BRANCH:         return FMT_B;
      OPC_LUI, OPC_AUIPC: return FMT_U;
      OPC_JAL:            return FMT_J;
      default:            return FMT_NONE;
    endcase
  endfunction

  function automatic logic [31:0] imm_of(input logic [31:0] insn);
    logic [31:0] v;
    v = '0;
    case (fmt_of(insn))
      FMT_I: begin
        // CSR numbers are zero-extended
        if (insn[6:0] == OPC_SYSTEM) v = {20'h0, insn[31:20]};
        else v = $signed(insn[31:20]);
      end
      FMT_S: v = $signed({insn[31:25], insn[11:7]});
      FMT_B: v = $signed({insn[31], insn[7], insn[30:25], insn[11:8], 1'b0});
      FMT_U: v = {insn[31:12], 12'h000};
      FMT_J: v = $signed({insn[31], insn[19:12], insn[20], insn[30:21], 1'b0});
      default: v = '0;
    endcase
    return v;
  endfunction

  function automatic trace_rec_t reference_record(input int h, input int idx,
                                                  input retire_t ret,
                                                  input logic [15:0] stamp);
    trace_rec_t r;
    r.hart       = HART_W'(h);
    r.cycle      = stamp;
    r.pc         = ret.pc;
    r.insn       = insn_tbl[idx].exp;
    r.compressed = insn_tbl[idx].cmp;
    r.illegal    = insn_tbl[idx].ill;
    r.fmt        = fmt_of(r.insn);
    r.imm        = imm_of(r.insn);
    r.rd_addr    = ret.rd_addr;
    r.rd_wdata   = ret.rd_wdata;
    return r;
  endfunction

  // Presents one retirement and waits for the edge that accepts it
  task automatic retire_one(input int h, input int idx, input logic [31:0] pc);
    retire_t ret;
    ret.insn     = insn_tbl[idx].raw;
    ret.pc       = pc;
    ret.rd_addr  = 5'($random(seed));
    ret.rd_wdata = $random(seed);
    retire_valid[h] <= 1'b1;
    retire[h]       <= ret;
    do @(posedge clk); while (!retire_ready[h]);
    exp_q[h].push_back(reference_record(h, idx, ret, edge_cnt));
    retire_valid[h] <= 1'b0;
  endtask

  task automatic random_traffic(input int h, input int count, input int max_gap);
    int idx;
    repeat (count) begin
      idx = $unsigned($random(seed)) % NUM_INSN;
      retire_one(h, idx, {4'(h), 28'($random(seed))});
      if (max_gap > 0) repeat ($unsigned($random(seed)) % (max_gap + 1)) @(posedge clk);
    end
  endtask

  task automatic compare_record(input trace_rec_t got, input trace_rec_t want);
    expect_equal("hart", 32'(got.hart), 32'(want.hart));
    expect_equal("cycle", 32'(got.cycle), 32'(want.cycle));
    expect_equal("pc", got.pc, want.pc);
    expect_equal("insn", got.insn, want.insn);
    expect_equal("compressed", 32'(got.compressed), 32'(want.compressed));
    expect_equal("illegal", 32'(got.illegal), 32'(want.illegal));
    expect_equal("fmt", 32'(got.fmt), 32'(want.fmt));
    expect_equal("imm", got.imm, want.imm);
    expect_equal("rd_addr", 32'(got.rd_addr), 32'(want.rd_addr));
    expect_equal("rd_wdata", got.rd_wdata, want.rd_wdata);
  endtask

  // Host side of the FIFO port
  task automatic drain_records(input int count);
    trace_rec_t got;
    int         h;
    repeat (count) begin
      do @(posedge clk); while (!out_req);
      got = out_rec;
      // Retiring hart comes from the pc, so the hart field is checked on its own
      h = int'(got.pc[31:28]);
      require(h < NUM_HARTS, "record carries a pc that belongs to no hart");
      require(exp_q[h].size() > 0, "record arrived that no retirement expects");
      compare_record(got, exp_q[h].pop_front());
      out_ack <= 1'b1;
      do @(posedge clk); while (out_req);
      out_ack <= 1'b0;
    end
  endtask

  task automatic reset_state();
    require(retire_ready[0] && retire_ready[1], "retire_ready_o is low after reset");
    require(!out_req, "out_req_o is high after reset");
    repeat (10) begin
      @(posedge clk);
      require(!out_req, "a record appeared without any retirement");
    end
  endtask

  task automatic cover_formats();
    fork
      for (int k = 0; k < 8; k++) retire_one(0, k, 32'h0000_1000 + 32'(4 * k));
      drain_records(8);
    join
  endtask

  task automatic expand_compressed();
    fork
      for (int k = 8; k < NUM_INSN; k++) retire_one(0, k, 32'h0000_2000 + 32'(2 * k));
      drain_records(NUM_INSN - 8);
    join
  endtask

  task automatic interleave_harts();
    fork
      random_traffic(0, 20, 2);
      random_traffic(1, 20, 2);
      drain_records(40);
    join
  endtask

  // Host holds off until both harts are stalled, then empties the FIFO
  task automatic stall_and_drain();
    int low_run;
    low_run = 0;
    fork
      random_traffic(0, 12, 0);
      random_traffic(1, 12, 0);
      begin
        // Both harts wait briefly during arbitration, a full FIFO keeps them low
        while (low_run < STALL_CYCLES) begin
          @(posedge clk);
          if (!retire_ready[0] && !retire_ready[1]) low_run++;
          else low_run = 0;
        end
        require(out_req, "both harts stalled with no record offered");
        drain_records(24);
      end
    join
  endtask

  initial begin
    seed    = 32'h4035;
    rst_n   = 1'b0;
    out_ack = 1'b0;
    for (int h = 0; h < NUM_HARTS; h++) begin
      retire_valid[h] = 1'b0;
      retire[h]       = '0;
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    reset_state();
    cover_formats();
    expand_compressed();
    interleave_harts();
    stall_and_drain();
    repeat (5) @(posedge clk);

    if (exp_q[0].size() == 0 && exp_q[1].size() == 0 && !out_req) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("Records left over: hart 0 %0d, hart 1 %0d", exp_q[0].size(),
               exp_q[1].size());
      $display("Regression failed");
      $fatal(1, "records missing or extra at end of run");
    end
  end

endmodule

// ==== trace_arbiter.sv ====
/*
  Round-robin arbiter over the per-hart four-phase links.
  Each granted request is pushed once, then acked; ack stays high until that
  req falls. While the FIFO is full the granted port simply waits.
*/
`timescale 1ns/1ps

module trace_arbiter
  import trace_pkg::*;
#(
  parameter int NUM_HARTS = 2
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_i      [NUM_HARTS],
  input  trace_rec_t rec_i      [NUM_HARTS],
  output logic       ack_o      [NUM_HARTS],
  output logic       push_o,
  output trace_rec_t push_rec_o,
  input  logic       full_i
);

  localparam int IDX_W = (NUM_HARTS > 1) ? $clog2(NUM_HARTS) : 1;

  typedef enum logic [1:0] {IDLE, PUSH, ACK} arb_state_e;

  arb_state_e       state_q;
  logic [IDX_W-1:0] last_q, next_idx;
  logic             any_req;

  // First requester after the last grant, wrapping around
  always_comb begin
    int idx;
    any_req  = 1'b0;
    next_idx = last_q;
    for (int k = 1; k <= NUM_HARTS; k++) begin
      idx = int'(last_q) + k;
      if (idx >= NUM_HARTS) idx = idx - NUM_HARTS;
      if (!any_req && req_i[idx]) begin
        any_req  = 1'b1;
        next_idx = IDX_W'(idx);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      last_q  <= IDX_W'(NUM_HARTS - 1);
    end else begin
      case (state_q)
        IDLE: begin
          if (any_req) begin
            last_q  <= next_idx;
            state_q <= PUSH;
          end
        end
        PUSH:    if (!full_i) state_q <= ACK;
        ACK:     if (!req_i[last_q]) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  assign push_o     = (state_q == PUSH) && !full_i;
  assign push_rec_o = rec_i[last_q];

  always_comb begin
    for (int h = 0; h < NUM_HARTS; h++) begin
      ack_o[h] = (state_q == ACK) && (last_q == IDX_W'(h));
    end
  end

endmodule

// ==== trace_encoder.sv ====
/*
  Per-hart trace encoder. Two records can be in flight: stage 1 and the
  hand-off register. The stamp counts rising edges since reset release,
  starting at 0, and wraps at 2^16. The hand-off uses four-phase req/ack
  and never changes rec_o while rec_req_o is high.
*/
`timescale 1ns/1ps

module trace_encoder
  import rv_isa_pkg::*, trace_pkg::*;
#(
  parameter int HART_ID = 0
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       retire_valid_i,
  input  retire_t    retire_i,
  output logic       retire_ready_o,
  output logic       rec_req_o,
  output trace_rec_t rec_o,
  input  logic       rec_ack_i
);

  typedef enum logic [1:0] {IDLE, REQ, WAIT_ACK_LOW} hs_state_e;

  hs_state_e          state_q, state_d;
  logic [CYCLE_W-1:0] cycle_q;
  logic               s1_valid_q;
  retire_t            s1_ret_q;
  logic [CYCLE_W-1:0] s1_cycle_q;
  trace_rec_t         rec_q, rec_d;
  logic               hs_free, hs_load, accept;
  logic [31:0]        exp_insn;
  logic               is_compressed, is_illegal;
  opcode_e            opcode;
  imm_fmt_e           fmt;
  logic [31:0]        imm;

  // Hand-off register can take a record once the previous ack is low
  assign hs_free        = (state_q == IDLE) || (state_q == WAIT_ACK_LOW && !rec_ack_i);
  assign hs_load        = s1_valid_q && hs_free;
  assign retire_ready_o = !s1_valid_q || hs_free;
  assign accept         = retire_valid_i && retire_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q    <= '0;
      s1_valid_q <= 1'b0;
      state_q    <= IDLE;
    end else begin
      cycle_q <= cycle_q + 1'b1;
      state_q <= state_d;
      if (accept) s1_valid_q <= 1'b1;
      else if (hs_load) s1_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      s1_ret_q   <= retire_i;
      s1_cycle_q <= cycle_q;
    end
    if (hs_load) rec_q <= rec_d;
  end

  compressed_decoder u_dec (
    .instr_i        (s1_ret_q.insn),
    .instr_o        (exp_insn),
    .is_compressed_o(is_compressed),
    .illegal_o      (is_illegal)
  );

  always_comb begin
    case (exp_insn[6:0])
      OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_JAL, OPC_JALR, OPC_OP_IMM, OPC_OP,
      OPC_LUI, OPC_AUIPC, OPC_SYSTEM: opcode = opcode_e'(exp_insn[6:0]);
      default: opcode = OPC_OTHER;
    endcase
  end

  // Immediate per format of the expanded word
  always_comb begin
    fmt = FMT_NONE;
    imm = '0;
    case (opcode)
      OPC_LOAD, OPC_JALR, OPC_OP_IMM: begin
        fmt = FMT_I;
        imm = {{20{exp_insn[31]}}, exp_insn[31:20]};
      end
      OPC_SYSTEM: begin
        fmt = FMT_I;
        imm = {20'b0, exp_insn[31:20]};
      end
      OPC_STORE: begin
        fmt = FMT_S;
        imm = {{20{exp_insn[31]}}, exp_insn[31:25], exp_insn[11:7]};
      end
      OPC_BRANCH: begin
        fmt = FMT_B;
        imm = {{20{exp_insn[31]}}, exp_insn[7], exp_insn[30:25], exp_insn[11:8], 1'b0};
      end
      OPC_LUI, OPC_AUIPC: begin
        fmt = FMT_U;
        imm = {exp_insn[31:12], 12'b0};
      end
      OPC_JAL: begin
        fmt = FMT_J;
        imm = {{12{exp_insn[31]}}, exp_insn[19:12], exp_insn[20], exp_insn[30:21], 1'b0};
      end
      default: ;
    endcase
  end

  always_comb begin
    rec_d.hart       = HART_W'(HART_ID);
    rec_d.cycle      = s1_cycle_q;
    rec_d.pc         = s1_ret_q.pc;
    rec_d.insn       = exp_insn;
    rec_d.compressed = is_compressed;
    rec_d.illegal    = is_illegal;
    rec_d.fmt        = fmt;
    rec_d.imm        = imm;
    rec_d.rd_addr    = s1_ret_q.rd_addr;
    rec_d.rd_wdata   = s1_ret_q.rd_wdata;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:         if (hs_load) state_d = REQ;
      REQ:          if (rec_ack_i) state_d = WAIT_ACK_LOW;
      WAIT_ACK_LOW: if (!rec_ack_i) state_d = hs_load ? REQ : IDLE;
      default:      state_d = IDLE;
    endcase
  end

  assign rec_req_o = (state_q == REQ);
  assign rec_o     = rec_q;

endmodule

// ==== trace_fifo.sv ====
/*
  Circular trace record buffer. FIFO_DEPTH must be a power of two, at least 2.
  A pushed record reaches out_req_o at the earliest one cycle later.
  Drain side is four-phase: pop on ack while req is high, next head only
  after ack has fallen. A push while full is dropped.
*/
`timescale 1ns/1ps

module trace_fifo
  import trace_pkg::*;
#(
  parameter int FIFO_DEPTH = 8
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       push_i,
  input  trace_rec_t push_rec_i,
  output logic       full_o,
  output logic       out_req_o,
  output trace_rec_t out_rec_o,
  input  logic       out_ack_i
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  typedef enum logic [1:0] {IDLE, OFFER, WAIT_ACK_LOW} drain_state_e;

  drain_state_e     state_q;
  trace_rec_t       mem_q [FIFO_DEPTH];
  trace_rec_t       out_rec_q;
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             do_push, do_pop, offer_load;

  assign full_o     = (count_q == (PTR_W + 1)'(FIFO_DEPTH));
  assign do_push    = push_i && !full_o;
  assign do_pop     = (state_q == OFFER) && out_ack_i;
  assign offer_load = (state_q == IDLE) && (count_q != '0);

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= push_rec_i;
    if (offer_load) out_rec_q <= mem_q[rd_ptr_q];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      state_q  <= IDLE;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (do_push && !do_pop) count_q <= count_q + 1'b1;
      else if (!do_push && do_pop) count_q <= count_q - 1'b1;
      case (state_q)
        IDLE:         if (offer_load) state_q <= OFFER;
        OFFER:        if (out_ack_i) state_q <= WAIT_ACK_LOW;
        WAIT_ACK_LOW: if (!out_ack_i) state_q <= IDLE;
        default:      state_q <= IDLE;
      endcase
    end
  end

  assign out_req_o = (state_q == OFFER);
  assign out_rec_o = out_rec_q;

endmodule

// ==== trace_pkg.sv ====
/*
  Trace types shared along the retire path.
  The hart field is HART_W bits wide, so at most four harts can be traced.
  The cycle stamp is 16 bits and wraps.
*/
package trace_pkg;
  import rv_isa_pkg::*;

  localparam int HART_W  = 2;
  localparam int CYCLE_W = 16;

  // One retirement as presented by a hart
  typedef struct packed {
    logic [31:0] insn;
    logic [31:0] pc;
    logic [4:0]  rd_addr;
    logic [31:0] rd_wdata;
  } retire_t;

  // One trace record, insn holds the expanded instruction
  typedef struct packed {
    logic [HART_W-1:0]  hart;
    logic [CYCLE_W-1:0] cycle;
    logic [31:0]        pc;
    logic [31:0]        insn;
    logic               compressed;
    logic               illegal;
    imm_fmt_e           fmt;
    logic [31:0]        imm;
    logic [4:0]         rd_addr;
    logic [31:0]        rd_wdata;
  } trace_rec_t;

endpackage

// ==== verilog.f ====
rv_isa_pkg.sv
trace_pkg.sv
compressed_decoder.sv
trace_encoder.sv
trace_arbiter.sv
trace_fifo.sv
rvfi_trace_top.sv
rvfi_trace_sva.sv
tb_rvfi_trace.sv
